//--- Bender.yml
package:
  name: pwm_ctrl

sources:
  # packages first, then leaf modules up to the top level
  - files:
      - src/pwm_bus_pkg.sv
      - src/pwm_cfg_pkg.sv
      - src/pwm_standard_gen.sv
      - src/pwm_heartbeat_gen.sv
      - src/pwm_channel.sv
      - src/pwm_reg_decode.sv
      - src/pwm_ctrl_top.sv

  - target: test
    files:
      - dv/pwm_tb_clk.sv
      - dv/pwm_tb_checker.sv
      - dv/pwm_ctrl_tb.sv

//--- files.f
src/pwm_bus_pkg.sv
src/pwm_cfg_pkg.sv
src/pwm_standard_gen.sv
src/pwm_heartbeat_gen.sv
src/pwm_channel.sv
src/pwm_reg_decode.sv
src/pwm_ctrl_top.sv
dv/pwm_tb_clk.sv
dv/pwm_tb_checker.sv
dv/pwm_ctrl_tb.sv

//--- dv/pwm_ctrl_tb.sv
// pwm controller testbench: table driven bus traffic and pin waveform checks

module pwm_ctrl_tb;

    import pwm_bus_pkg::*;

    localparam int DRIVE_DLY = 10;

    typedef enum logic [2:0] {
        OP_WR, OP_RD, OP_RND, OP_OUT, OP_LVL, OP_PULSE
    } op_e;

    typedef struct packed {
        op_e         op;
        logic        ch;
        logic [5:0]  adr;
        logic [31:0] dat;    // write data, readback mask for random entries
        logic [31:0] exp;    // read value, or pin level for OP_LVL
        logic [7:0]  per;
        logic [7:0]  lo;
        logic [7:0]  hi;
        logic [7:0]  step;
        logic [7:0]  n;      // cycles or pulses to watch
    } stim_t;

    logic        clk;
    logic        rst;
    logic [5:0]  wb_adr;
    logic [31:0] wb_dat;
    logic        wb_we;
    logic        wb_cyc;
    logic        wb_stb;
    logic [3:0]  wb_sel;
    logic [31:0] wb_rdat;
    logic        wb_ack;
    logic [1:0]  pwm;
    stim_t       tbl[$];
    int          seed_init;

    pwm_tb_clk #(.PERIOD(100), .RST_CYCLES(5)) u_clk (.clk_o(clk), .rst_o(rst));

    pwm_ctrl_top UUT (
        .clk_i    (clk),
        .rst_i    (rst),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat),
        .wb_we_i  (wb_we),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_sel_i (wb_sel),
        .wb_dat_o (wb_rdat),
        .wb_ack_o (wb_ack),
        .pwm_o    (pwm)
    );

    pwm_tb_checker u_chk (
        .clk_i (clk),
        .rst_i (rst),
        .ack_i (wb_ack),
        .dat_i (wb_rdat),
        .pwm_i (pwm)
    );

    function automatic stim_t bus_entry(op_e op, logic [5:0] adr, logic [31:0] dat,
                                        logic [31:0] exp);
        stim_t s;
        s     = '0;
        s.op  = op;
        s.adr = adr;
        s.ch  = (adr == REG_OUT1);
        s.dat = dat;
        s.exp = exp;
        return s;
    endfunction

    function automatic stim_t level_entry(logic ch, logic val, int n);
        stim_t s;
        s     = '0;
        s.op  = OP_LVL;
        s.ch  = ch;
        s.exp = {31'b0, val};
        s.n   = n;
        return s;
    endfunction

    function automatic stim_t pulse_entry(logic ch, int per, int lo, int hi, int step, int n);
        stim_t s;
        s      = '0;
        s.op   = OP_PULSE;
        s.ch   = ch;
        s.per  = per;
        s.lo   = lo;
        s.hi   = hi;
        s.step = step;
        s.n    = n;
        return s;
    endfunction

    task automatic fill_table();
        // out of reset everything idle
        tbl.push_back(level_entry(0, 1'b0, 10));
        tbl.push_back(level_entry(1, 1'b0, 10));
        tbl.push_back(bus_entry(OP_RD, REG_OUT0, '0, 32'h0));
        tbl.push_back(bus_entry(OP_RD, REG_OUT1, '0, 32'h0));
        tbl.push_back(bus_entry(OP_RD, REG_CTRL0, '0, 32'h0));
        tbl.push_back(bus_entry(OP_RD, REG_PERIOD1, '0, 32'h0));
        // random readback, masked to each field
        tbl.push_back(bus_entry(OP_RND, REG_CTRL0, 32'h3, '0));
        tbl.push_back(bus_entry(OP_RND, REG_CTRL1, 32'h3, '0));
        tbl.push_back(bus_entry(OP_RND, REG_PERIOD0, 32'hFFFF_FFFF, '0));
        tbl.push_back(bus_entry(OP_RND, REG_PERIOD1, 32'hFFFF_FFFF, '0));
        tbl.push_back(bus_entry(OP_RND, REG_THR0_LO, 32'hFFFF_FFFF, '0));
        tbl.push_back(bus_entry(OP_RND, REG_THR0_HI, 32'hFFFF_FFFF, '0));
        tbl.push_back(bus_entry(OP_RND, REG_THR1_LO, 32'hFFFF_FFFF, '0));
        tbl.push_back(bus_entry(OP_RND, REG_THR1_HI, 32'hFFFF_FFFF, '0));
        tbl.push_back(bus_entry(OP_RND, REG_STEP0, 32'hFFF, '0));
        tbl.push_back(bus_entry(OP_RND, REG_STEP1, 32'hFFF, '0));
        tbl.push_back(bus_entry(OP_RND, 6'h30, 32'h0, '0));   // holes read zero
        tbl.push_back(bus_entry(OP_RND, 6'h3C, 32'h0, '0));
        tbl.push_back(bus_entry(OP_WR, REG_CTRL0, 32'h0, '0));
        tbl.push_back(bus_entry(OP_WR, REG_CTRL1, 32'h0, '0));
        tbl.push_back(bus_entry(OP_WR, REG_OUT0, 32'h1, '0));
        tbl.push_back(bus_entry(OP_RD, REG_OUT0, '0, 32'h0));
        // mode 3 behaves as idle
        tbl.push_back(bus_entry(OP_WR, REG_PERIOD0, 32'd10, '0));
        tbl.push_back(bus_entry(OP_WR, REG_THR0_LO, 32'd3, '0));
        tbl.push_back(bus_entry(OP_WR, REG_CTRL0, 32'h3, '0));
        tbl.push_back(bus_entry(OP_RD, REG_CTRL0, '0, 32'h3));
        tbl.push_back(level_entry(0, 1'b0, 30));
        tbl.push_back(bus_entry(OP_RD, REG_OUT0, '0, 32'h0));
        // standard mode on channel 0
        tbl.push_back(bus_entry(OP_WR, REG_CTRL0, 32'h1, '0));
        tbl.push_back(pulse_entry(0, 10, 3, 3, 0, 4));
        tbl.push_back(bus_entry(OP_WR, REG_THR0_LO, 32'd12, '0));
        tbl.push_back(level_entry(0, 1'b1, 30));
        tbl.push_back(bus_entry(OP_WR, REG_THR0_LO, 32'd10, '0));
        tbl.push_back(level_entry(0, 1'b1, 30));
        tbl.push_back(bus_entry(OP_WR, REG_THR0_LO, 32'd7, '0));
        tbl.push_back(pulse_entry(0, 10, 7, 7, 0, 3));
        // heartbeat on channel 1 while channel 0 keeps running
        tbl.push_back(bus_entry(OP_WR, REG_PERIOD1, 32'd20, '0));
        tbl.push_back(bus_entry(OP_WR, REG_THR1_LO, 32'd4, '0));
        tbl.push_back(bus_entry(OP_WR, REG_THR1_HI, 32'd14, '0));
        tbl.push_back(bus_entry(OP_WR, REG_STEP1, 32'd4, '0));
        tbl.push_back(bus_entry(OP_WR, REG_CTRL1, 32'h2, '0));
        tbl.push_back(pulse_entry(1, 20, 4, 14, 4, 9));
        tbl.push_back(pulse_entry(0, 10, 7, 7, 0, 3));
        tbl.push_back(bus_entry(OP_OUT, REG_OUT0, '0, '0));
        tbl.push_back(bus_entry(OP_OUT, REG_OUT1, '0, '0));
        tbl.push_back(bus_entry(OP_WR, REG_CTRL0, 32'h0, '0));
        tbl.push_back(level_entry(0, 1'b0, 20));
        tbl.push_back(bus_entry(OP_RD, REG_OUT0, '0, 32'h0));
        tbl.push_back(bus_entry(OP_OUT, REG_OUT1, '0, '0));
        // step does not divide the range, both bounds clamp
        tbl.push_back(bus_entry(OP_WR, REG_CTRL1, 32'h0, '0));
        tbl.push_back(bus_entry(OP_WR, REG_PERIOD1, 32'd16, '0));
        tbl.push_back(bus_entry(OP_WR, REG_THR1_LO, 32'd2, '0));
        tbl.push_back(bus_entry(OP_WR, REG_THR1_HI, 32'd11, '0));
        tbl.push_back(bus_entry(OP_WR, REG_CTRL1, 32'h2, '0));
        tbl.push_back(pulse_entry(1, 16, 2, 11, 4, 8));
    endtask

    // one classic cycle, held until ack, released after the next edge
    task automatic bus_access(input logic we, input logic [5:0] adr, input logic [31:0] dat,
                              output logic [31:0] rdata, output logic [1:0] req_pin);
        int lat;
        @(posedge clk);
        #DRIVE_DLY;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = we;
        wb_adr = adr;
        wb_dat = dat;
        u_chk.wait_ack(lat, rdata, req_pin);
        u_chk.check_eq($sformatf("ack latency at offset %h", adr), lat, 32'd1);
        @(posedge clk);
        #DRIVE_DLY;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic run_entry(input stim_t s);
        logic [31:0] rdata;
        logic [31:0] val;
        logic [1:0]  req_pin;
        case (s.op)
            OP_WR: bus_access(1'b1, s.adr, s.dat, rdata, req_pin);
            OP_RD: begin
                bus_access(1'b0, s.adr, '0, rdata, req_pin);
                u_chk.check_eq($sformatf("read of offset %h", s.adr), rdata, s.exp);
            end
            OP_RND: begin
                val = $urandom;
                bus_access(1'b1, s.adr, val, rdata, req_pin);
                bus_access(1'b0, s.adr, '0, rdata, req_pin);
                u_chk.check_eq($sformatf("readback of offset %h", s.adr), rdata, val & s.dat);
            end
            OP_OUT: begin
                bus_access(1'b0, s.adr, '0, rdata, req_pin);
                u_chk.check_eq($sformatf("live pin %0d read", s.ch), rdata,
                               {31'b0, req_pin[s.ch]});
            end
            OP_LVL:   u_chk.check_level(s.ch, s.exp[0], s.n);
            OP_PULSE: u_chk.check_pulses(s.ch, s.per, s.lo, s.hi, s.step, s.n);
            default: ;
        endcase
    endtask

    initial begin
        int i;
        wb_adr    = '0;
        wb_dat    = '0;
        wb_we     = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_sel    = 4'hF;
        seed_init = $urandom(32'h770a2818);
        fill_table();
        u_chk.wait_reset();
        for (i = 0; i < tbl.size(); i++) begin
            run_entry(tbl[i]);
        end
        $display("checks done: %0d errors, %0d timeouts", u_chk.err_cnt, u_chk.tmo_cnt);
        if (u_chk.err_cnt == 0 && u_chk.tmo_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- dv/pwm_tb_checker.sv
// pwm testbench checker: samples bus responses and pin waveforms, compares with expectations

module pwm_tb_checker (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        ack_i,
    input  logic [31:0] dat_i,
    input  logic [1:0]  pwm_i
);

    int         err_cnt  = 0;
    int         tmo_cnt  = 0;
    logic [1:0] pin_last = '0;   // pins at the latest falling edge

    // outputs change on the rising edge, the falling edge sees them settled
    always @(negedge clk_i) begin
        pin_last <= pwm_i;
    end

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        tmo_cnt++;
        $display("timeout at %0t: gave up waiting for %s", $time, what);
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst_i && n < 20) begin
            @(posedge clk_i);
            n++;
        end
        if (rst_i) note_timeout("reset release");
    endtask

    // lat counts the edges between request and ack, req_pin is the pin level it sampled
    task automatic wait_ack(output int lat, output logic [31:0] data,
                            output logic [1:0] req_pin);
        logic done;
        lat     = 0;
        data    = '0;
        req_pin = '0;
        done    = 1'b0;
        while (!done && lat < 20) begin
            @(negedge clk_i);
            if (ack_i) begin
                data = dat_i;
                done = 1'b1;
            end else begin
                req_pin = pwm_i;
                lat++;
            end
        end
        if (!done) note_timeout("bus ack");
    endtask

    task automatic check_level(input int ch, input logic val, input int n);
        int   i;
        logic bad;
        bad = 1'b0;
        @(negedge clk_i);   // the pin may still be turning in the first cycle
        for (i = 0; i < n; i++) begin
            @(negedge clk_i);
            if (pwm_i[ch] !== val && !bad) begin
                bad = 1'b1;
                err_cnt++;
                $display("** Error at %0t: pin %0d is %b, expected to hold %b",
                         $time, ch, pwm_i[ch], val);
            end
        end
        #10;
    endtask

    // widths ramp from lo by step, reverse at each bound, clamped to [lo, hi]
    task automatic check_pulses(input int ch, input int per, input int lo, input int hi,
                                input int step, input int n);
        int   lim;
        int   d;
        int   width;
        int   len;
        int   k;
        logic up;
        logic prev;
        logic rise;
        logic low_seen;
        lim  = 4 * per + 20;
        d    = lo;
        up   = 1'b1;
        prev = pin_last[ch];
        rise = 1'b0;
        len  = 0;
        while (!rise && len < lim) begin
            @(negedge clk_i);
            rise = pwm_i[ch] && !prev;
            prev = pwm_i[ch];
            len++;
        end
        if (!rise) note_timeout($sformatf("first pulse on pin %0d", ch));
        for (k = 0; k < n && rise; k++) begin
            width    = 1;
            len      = 0;
            low_seen = 1'b0;
            rise     = 1'b0;
            while (!rise && len < lim) begin
                @(negedge clk_i);
                len++;
                if (pwm_i[ch]) begin
                    if (low_seen) rise = 1'b1;
                    else width++;
                end else begin
                    low_seen = 1'b1;
                end
            end
            if (!rise) begin
                note_timeout($sformatf("pulse %0d on pin %0d", k + 1, ch));
            end else begin
                if (width != d) begin
                    err_cnt++;
                    $display("** Error at %0t: pulse %0d on pin %0d is %0d cycles, expected %0d",
                             $time, k, ch, width, d);
                end
                if (len != per) begin
                    err_cnt++;
                    $display("** Error at %0t: pin %0d rises %0d cycles apart, expected %0d",
                             $time, ch, len, per);
                end
                // one step on in the current direction, held inside the bounds
                if (up) begin
                    d = (d + step > hi) ? hi : d + step;
                end else begin
                    d = (d - step < lo) ? lo : d - step;
                end
                if (d == hi) begin
                    up = 1'b0;   // turns around on reaching a bound
                end else if (d == lo) begin
                    up = 1'b1;
                end
            end
        end
        #10;
    endtask

endmodule

//--- dv/pwm_tb_clk.sv
// testbench clock and reset source for the pwm controller

module pwm_tb_clk #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // released just after the last reset edge
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        #10;
        rst_o = 1'b0;
    end

endmodule

//--- src/pwm_ctrl_top.sv
// two channel pwm controller with a wishbone classic register port

module pwm_ctrl_top #(
    parameter int RESOLUTION = 32
) (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [5:0]  wb_adr_i,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_we_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic [3:0]  wb_sel_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,
    output logic [1:0]  pwm_o
);

    import pwm_bus_pkg::*;
    import pwm_cfg_pkg::*;

    wb_req_t     bus_req;
    wb_rsp_t     bus_rsp;
    pwm_ch_cfg_t cfg0;
    pwm_ch_cfg_t cfg1;
    logic [1:0]  pin;

    assign bus_req  = '{cyc: wb_cyc_i, stb: wb_stb_i, we: wb_we_i,
                        adr: wb_adr_i, dat: wb_dat_i, sel: wb_sel_i};
    assign wb_ack_o = bus_rsp.ack;
    assign wb_dat_o = bus_rsp.dat;
    assign pwm_o    = pin;

    pwm_reg_decode #(
        .RESOLUTION (RESOLUTION)
    ) u_decode (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .req_i  (bus_req),
        .pin_i  (pin),      // fed back for the out registers
        .rsp_o  (bus_rsp),
        .cfg0_o (cfg0),
        .cfg1_o (cfg1)
    );

    pwm_channel #(
        .RESOLUTION (RESOLUTION)
    ) u_ch0 (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .cfg_i (cfg0),
        .pin_o (pin[0])
    );

    pwm_channel #(
        .RESOLUTION (RESOLUTION)
    ) u_ch1 (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .cfg_i (cfg1),
        .pin_o (pin[1])
    );

endmodule

//--- src/pwm_reg_decode.sv
// pwm register decoder: wishbone classic slave holding both channel configurations

module pwm_reg_decode #(
    parameter int RESOLUTION = 32
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  pwm_bus_pkg::wb_req_t     req_i,
    input  logic [1:0]               pin_i,
    output pwm_bus_pkg::wb_rsp_t     rsp_o,
    output pwm_cfg_pkg::pwm_ch_cfg_t cfg0_o,
    output pwm_cfg_pkg::pwm_ch_cfg_t cfg1_o
);

    import pwm_bus_pkg::*;
    import pwm_cfg_pkg::*;

    pwm_ch_cfg_t cfg0_q;
    pwm_ch_cfg_t cfg1_q;
    logic        ack_q;
    logic [31:0] rd_q;
    logic [31:0] rdata;
    logic        access;

    // keep only the counter bits, upper bits read back as zero
    function automatic logic [31:0] zext_res(input logic [31:0] d);
        logic [31:0] r;
        r = '0;
        r[RESOLUTION-1:0] = d[RESOLUTION-1:0];
        return r;
    endfunction

    // new request seen, ack goes out on the next edge
    assign access = req_i.cyc && req_i.stb && !ack_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
            rd_q  <= '0;
        end else begin
            ack_q <= access;
            if (access) begin
                rd_q <= req_i.we ? '0 : rdata;
            end
        end
    end

    // register writes land on the edge that raises ack
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cfg0_q <= '0;
            cfg1_q <= '0;
        end else if (access && req_i.we) begin
            case (req_i.adr)
                REG_CTRL0:   cfg0_q.mode   <= pwm_mode_e'(req_i.dat[1:0]);
                REG_CTRL1:   cfg1_q.mode   <= pwm_mode_e'(req_i.dat[1:0]);
                REG_PERIOD0: cfg0_q.period <= zext_res(req_i.dat);
                REG_PERIOD1: cfg1_q.period <= zext_res(req_i.dat);
                REG_THR0_LO: cfg0_q.thr_lo <= zext_res(req_i.dat);
                REG_THR0_HI: cfg0_q.thr_hi <= zext_res(req_i.dat);
                REG_THR1_LO: cfg1_q.thr_lo <= zext_res(req_i.dat);
                REG_THR1_HI: cfg1_q.thr_hi <= zext_res(req_i.dat);
                REG_STEP0:   cfg0_q.step   <= req_i.dat[STEP_W-1:0];
                REG_STEP1:   cfg1_q.step   <= req_i.dat[STEP_W-1:0];
                default: ;   // out regs and holes drop the write
            endcase
        end
    end

    // read mux, narrow fields zero extended
    always_comb begin
        rdata = '0;
        case (req_i.adr)
            REG_CTRL0:   rdata = 32'(cfg0_q.mode);
            REG_CTRL1:   rdata = 32'(cfg1_q.mode);
            REG_PERIOD0: rdata = cfg0_q.period;
            REG_PERIOD1: rdata = cfg1_q.period;
            REG_THR0_LO: rdata = cfg0_q.thr_lo;
            REG_THR0_HI: rdata = cfg0_q.thr_hi;
            REG_THR1_LO: rdata = cfg1_q.thr_lo;
            REG_THR1_HI: rdata = cfg1_q.thr_hi;
            REG_STEP0:   rdata = 32'(cfg0_q.step);
            REG_STEP1:   rdata = 32'(cfg1_q.step);
            REG_OUT0:    rdata = {31'b0, pin_i[0]};
            REG_OUT1:    rdata = {31'b0, pin_i[1]};
            default:     rdata = '0;
        endcase
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rd_q;
    assign cfg0_o    = cfg0_q;
    assign cfg1_o    = cfg1_q;

    // single cycle ack, master must drop stb once it sees it
    a_ack_single: assert property (
        @(posedge clk_i) disable iff (rst_i)
        rsp_o.ack |=> !rsp_o.ack
    );

    // ack only answers a request from the previous cycle
    a_ack_after_req: assert property (
        @(posedge clk_i) disable iff (rst_i)
        rsp_o.ack |-> $past(req_i.cyc && req_i.stb)
    );

endmodule

//--- src/pwm_channel.sv
// pwm channel: both generators, mode based enables and the registered pin

module pwm_channel #(
    parameter int RESOLUTION = 32
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  pwm_cfg_pkg::pwm_ch_cfg_t cfg_i,
    output logic                     pin_o
);

    import pwm_cfg_pkg::*;

    logic en_std;
    logic en_hb;
    logic std_raw;
    logic hb_raw;
    logic pin_q;

    // only the generator for the active mode runs
    assign en_std = (cfg_i.mode == MODE_STANDARD);
    assign en_hb  = (cfg_i.mode == MODE_HEARTBEAT);

    pwm_standard_gen #(
        .RESOLUTION (RESOLUTION)
    ) u_std (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .en_i     (en_std),
        .period_i (cfg_i.period[RESOLUTION-1:0]),
        .thr_i    (cfg_i.thr_lo[RESOLUTION-1:0]),
        .pwm_o    (std_raw)
    );

    pwm_heartbeat_gen #(
        .RESOLUTION (RESOLUTION)
    ) u_hb (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .en_i     (en_hb),
        .period_i (cfg_i.period[RESOLUTION-1:0]),
        .thr_lo_i (cfg_i.thr_lo[RESOLUTION-1:0]),
        .thr_hi_i (cfg_i.thr_hi[RESOLUTION-1:0]),
        .step_i   (cfg_i.step),
        .pwm_o    (hb_raw)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pin_q <= 1'b0;
        end else begin
            pin_q <= en_std ? std_raw : hb_raw;   // idle and 3 leave both generators low
        end
    end

    assign pin_o = pin_q;

    a_idle_low: assert property (
        @(posedge clk_i) disable iff (rst_i)
        $past(!en_std && !en_hb) |-> !pin_o
    );

endmodule

//--- src/pwm_heartbeat_gen.sv
// heartbeat pwm generator: duty ramps between two thresholds once per period

module pwm_heartbeat_gen #(
    parameter int RESOLUTION = 32
) (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           en_i,
    input  logic [RESOLUTION-1:0]          period_i,
    input  logic [RESOLUTION-1:0]          thr_lo_i,
    input  logic [RESOLUTION-1:0]          thr_hi_i,
    input  logic [pwm_cfg_pkg::STEP_W-1:0] step_i,
    output logic                           pwm_o
);

    import pwm_cfg_pkg::*;

    localparam int SUM_W = RESOLUTION + 1;   // one spare bit for the ramp sums

    logic [RESOLUTION-1:0] cnt_q;
    logic [RESOLUTION-1:0] duty_q;
    logic [RESOLUTION-1:0] duty_cur;
    logic                  dir_up_q;
    logic                  per_zero;
    logic                  wrap;
    logic [SUM_W-1:0]      step_ext;
    logic [SUM_W-1:0]      up_sum;
    logic [SUM_W-1:0]      lo_reach;

    assign per_zero = (period_i == '0);
    assign wrap     = per_zero || (cnt_q >= period_i - 1'b1);

    // duty pulled back inside the bounds if they move under it
    always_comb begin
        duty_cur = duty_q;
        if (duty_cur < thr_lo_i) duty_cur = thr_lo_i;
        if (duty_cur > thr_hi_i) duty_cur = thr_hi_i;
    end

    assign step_ext = SUM_W'(step_i);
    assign up_sum   = {1'b0, duty_cur} + step_ext;
    assign lo_reach = {1'b0, thr_lo_i} + step_ext;   // at or below this, next step hits lo

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q    <= '0;
            duty_q   <= '0;
            dir_up_q <= 1'b1;
        end else if (!en_i) begin
            cnt_q    <= '0;
            duty_q   <= thr_lo_i;   // ramp restarts at the lower bound
            dir_up_q <= 1'b1;
        end else if (wrap) begin
            cnt_q <= '0;
            if (dir_up_q) begin
                if (up_sum >= {1'b0, thr_hi_i}) begin
                    duty_q   <= thr_hi_i;
                    dir_up_q <= 1'b0;
                end else begin
                    duty_q <= up_sum[RESOLUTION-1:0];
                end
            end else begin
                if ({1'b0, duty_cur} <= lo_reach) begin
                    duty_q   <= thr_lo_i;
                    dir_up_q <= 1'b1;
                end else begin
                    duty_q <= duty_cur - step_ext[RESOLUTION-1:0];
                end
            end
        end else begin
            cnt_q  <= cnt_q + 1'b1;
            duty_q <= duty_cur;
        end
    end

    assign pwm_o = en_i && !per_zero && (cnt_q < duty_cur);

    // bounds held steady for a cycle, the stored duty sits between them
    a_duty_in_bounds: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (en_i && (thr_lo_i <= thr_hi_i) && $stable(thr_lo_i) && $stable(thr_hi_i))
            |-> (duty_q >= thr_lo_i) && (duty_q <= thr_hi_i)
    );

endmodule

//--- src/pwm_standard_gen.sv
// standard pwm generator: wrapping period counter against a fixed duty threshold

module pwm_standard_gen #(
    parameter int RESOLUTION = 32
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  en_i,
    input  logic [RESOLUTION-1:0] period_i,
    input  logic [RESOLUTION-1:0] thr_i,
    output logic                  pwm_o
);

    logic [RESOLUTION-1:0] cnt_q;
    logic                  per_zero;
    logic                  wrap;

    assign per_zero = (period_i == '0);

    // >= so a period shortened mid-run still wraps
    assign wrap = per_zero || (cnt_q >= period_i - 1'b1);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (!en_i) begin
            cnt_q <= '0;     // held while another mode owns the pin
        end else if (wrap) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // thr >= period keeps the output high, period 0 keeps it low
    assign pwm_o = en_i && !per_zero && (cnt_q < thr_i);

endmodule

//--- src/pwm_cfg_pkg.sv
// pwm configuration package: channel modes and the per-channel register set

package pwm_cfg_pkg;

    // width of the heartbeat step register
    localparam int STEP_W = 12;

    // value 3 is not listed and behaves as idle
    typedef enum logic [1:0] {
        MODE_IDLE      = 2'd0,
        MODE_STANDARD  = 2'd1,
        MODE_HEARTBEAT = 2'd2
    } pwm_mode_e;

    // one channel's configuration as held by the decoder
    // counter fields are 32 bits, only the low RESOLUTION bits are used
    typedef struct packed {
        pwm_mode_e         mode;
        logic [31:0]       period;
        logic [31:0]       thr_lo;   // standard duty, heartbeat lower bound
        logic [31:0]       thr_hi;   // heartbeat upper bound
        logic [STEP_W-1:0] step;
    } pwm_ch_cfg_t;

endpackage

//--- src/pwm_bus_pkg.sv
// pwm bus package: wishbone request/response structs and the register map

package pwm_bus_pkg;

    // wishbone classic request, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [5:0]  adr;   // byte offset inside the block
        logic [31:0] dat;
        logic [3:0]  sel;   // ignored, every write is a full word
    } wb_req_t;

    // wishbone classic response, slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // channel 0 and 1 mode registers
    localparam logic [5:0] REG_CTRL0   = 6'h00;
    localparam logic [5:0] REG_CTRL1   = 6'h04;

    // period length in clock cycles
    localparam logic [5:0] REG_PERIOD0 = 6'h08;
    localparam logic [5:0] REG_PERIOD1 = 6'h0C;

    // lo threshold doubles as the standard mode duty
    localparam logic [5:0] REG_THR0_LO = 6'h10;
    localparam logic [5:0] REG_THR0_HI = 6'h14;
    localparam logic [5:0] REG_THR1_LO = 6'h18;
    localparam logic [5:0] REG_THR1_HI = 6'h1C;

    // heartbeat ramp step
    localparam logic [5:0] REG_STEP0   = 6'h20;
    localparam logic [5:0] REG_STEP1   = 6'h24;

    // live pin levels, read only
    localparam logic [5:0] REG_OUT0    = 6'h28;
    localparam logic [5:0] REG_OUT1    = 6'h2C;

endpackage
